/* Bender.yml */
package:
  name: uart_string_link

sources:
  - files:
      - common/uart_string_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - string_link/string_framer.sv
      - string_link/string_deframer.sv
      - hw/uart_string_link.sv

  - target: simulation
    files:
      - verification/tb_uart_string_link.sv

/* common/uart_string_pkg.sv */
//==========================================================================
// shared types and constants for the uart string link
// 8N1 receive and 8N2 transmit at a fixed baud, derived from a 50 MHz clock
// payload limited to MAX_LEN bytes, byte 0 in the lowest bits of string_t
// state literals carry a prefix so the three enums can share one scope
//==========================================================================
`default_nettype none

package uart_string_pkg;

	typedef logic [7:0] byte_t;

	localparam int MAX_LEN = 32;

	// 6 bits, so oversize requests stay visible before clamping
	typedef logic [5:0] len_t;
	typedef logic [8*MAX_LEN-1:0] string_t;

	typedef struct packed {
		string_t data;
		len_t    length;
	} str_msg_t;

	// baud timing
	localparam int CLK_FREQ_HZ = 50_000_000;
	localparam int BAUD_RATE   = 115_200;

	typedef logic [15:0] baud_cnt_t;

	localparam baud_cnt_t CLKS_PER_BIT      = baud_cnt_t'(CLK_FREQ_HZ / BAUD_RATE);
	localparam baud_cnt_t CLKS_PER_HALF_BIT = baud_cnt_t'(CLK_FREQ_HZ / BAUD_RATE / 2);

	localparam int TX_STOP_BITS = 2;

	// frame delimiter, the character "&"
	localparam byte_t DELIM = 8'h26;

	typedef enum logic [2:0] {
		FR_IDLE, FR_OPEN1, FR_OPEN2, FR_PAYLOAD, FR_CLOSE1, FR_CLOSE2, FR_FINISH
	} framer_state_t;

	typedef enum logic [1:0] {
		DF_HUNT, DF_OPEN2, DF_CONTENT, DF_CLOSE2
	} deframer_state_t;

	// used by both uart_rx and uart_tx
	typedef enum logic [1:0] {
		UART_IDLE, UART_START, UART_DATA, UART_STOP
	} uart_state_t;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
//==========================================================================
// uart receiver, 8 data bits, no parity, one stop bit checked
// rxd passes two sync flops, bits are sampled at mid-bit
// a low stop bit drops the byte without any error indication
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import uart_string_pkg::*;
(
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire         rxd,
	output byte_t       rx_byte,
	output logic        rx_valid
);

	logic [2:0]  rxd_sync;
	logic        line;
	logic        line_fall;
	uart_state_t state;
	baud_cnt_t   cnt;
	logic [2:0]  bit_idx;
	byte_t       shift_q;

	// bit 1 is the synchronised line, bit 2 its previous value
	assign line      = rxd_sync[1];
	assign line_fall = rxd_sync[2] & ~rxd_sync[1];
	assign rx_byte   = shift_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_sync <= '1;
		end else begin
			rxd_sync <= {rxd_sync[1:0], rxd};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= UART_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				UART_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (line_fall)
						state <= UART_START;
				end
				UART_START: begin
					// glitch shorter than half a bit goes back to idle
					if (cnt == CLKS_PER_HALF_BIT - 16'd1) begin
						cnt   <= '0;
						state <= line ? UART_IDLE : UART_DATA;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				UART_DATA: begin
					if (cnt == CLKS_PER_BIT - 16'd1) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= UART_STOP;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				UART_STOP: begin
					if (cnt == CLKS_PER_BIT - 16'd1) begin
						cnt      <= '0;
						rx_valid <= line;
						state    <= UART_IDLE;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// lsb first, shifted in from the top
	always_ff @(posedge sys_clk) begin
		if (state == UART_DATA && cnt == CLKS_PER_BIT - 16'd1)
			shift_q <= {line, shift_q[7:1]};
	end

endmodule

`default_nettype wire

/* hw/uart_string_link.sv */
//==========================================================================
// uart string link top, receive chain and transmit chain side by side
// the two chains are independent, loopback is left to the outside
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_string_link
	import uart_string_pkg::*;
(
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire str_msg_t tx_msg,
	input  wire           tx_req,
	output logic          tx_busy,
	output logic          tx_done,
	output str_msg_t      rx_msg,
	output logic          rx_busy,
	output logic          rx_done,
	output logic          rx_error,
	input  wire           uart_rx_port,
	output logic          uart_tx_port
);

	byte_t rx_byte;
	logic  rx_valid;
	byte_t tx_byte;
	logic  tx_start;
	logic  tx_byte_done;

	// receive chain
	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	string_deframer u_deframer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

	// transmit chain
	string_framer u_framer (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.tx_byte      (tx_byte),
		.tx_start     (tx_start),
		.tx_byte_done (tx_byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_byte      (tx_byte),
		.tx_start     (tx_start),
		.txd          (uart_tx_port),
		.tx_byte_done (tx_byte_done)
	);

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
//==========================================================================
// uart transmitter, start bit, 8 data bits lsb first, TX_STOP_BITS stops
// tx_start is only legal while idle, there is no request queue
// tx_byte_done marks the last cycle of the final stop bit
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_tx
	import uart_string_pkg::*;
(
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire byte_t  tx_byte,
	input  wire         tx_start,
	output logic        txd,
	output logic        tx_byte_done
);

	localparam logic [2:0] STOP_LAST = 3'(TX_STOP_BITS - 1);

	uart_state_t state;
	baud_cnt_t   cnt;
	logic [2:0]  bit_idx;
	byte_t       byte_q;
	logic        bit_end;

	assign bit_end      = (cnt == CLKS_PER_BIT - 16'd1);
	assign tx_byte_done = (state == UART_STOP) && bit_end && (bit_idx == STOP_LAST);

	always_ff @(posedge sys_clk) begin
		if (tx_start && state == UART_IDLE)
			byte_q <= tx_byte;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= UART_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
		end else begin
			cnt <= bit_end ? '0 : cnt + 16'd1;
			case (state)
				UART_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (tx_start) begin
						txd   <= 1'b0;
						state <= UART_START;
					end
				end
				UART_START: begin
					if (bit_end) begin
						txd   <= byte_q[0];
						state <= UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							txd     <= 1'b1;
							bit_idx <= '0;
							state   <= UART_STOP;
						end else begin
							txd     <= byte_q[bit_idx + 3'd1];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				UART_STOP: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == STOP_LAST)
							state <= UART_IDLE;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// the framer must wait for tx_byte_done before the next byte
	a_start_only_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_start |-> state == UART_IDLE
	);

endmodule

`default_nettype wire

/* string_link/string_deframer.sv */
//==========================================================================
// finds "&&payload&&" frames in the received byte stream
// a single "&" inside the payload is kept, "&&" always closes the frame
// payload over MAX_LEN bytes gives rx_error and rx_msg keeps its old value
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module string_deframer
	import uart_string_pkg::*;
(
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire byte_t  rx_byte,
	input  wire         rx_valid,
	output str_msg_t    rx_msg,
	output logic        rx_busy,
	output logic        rx_done,
	output logic        rx_error
);

	deframer_state_t state;
	string_t         data_q;
	len_t            cnt_q;
	logic            is_delim;
	logic            frame_end;
	logic            store_one;
	logic            store_pair;
	logic            overflow;

	assign is_delim = (rx_byte == DELIM);
	assign rx_busy  = (state != DF_HUNT);

	// second "&" after a held one closes the frame
	assign frame_end  = rx_valid && (state == DF_CLOSE2) && is_delim;
	assign store_one  = rx_valid && (state == DF_CONTENT) && !is_delim
	                    && (cnt_q < len_t'(MAX_LEN));
	// held "&" plus the current byte
	assign store_pair = rx_valid && (state == DF_CLOSE2) && !is_delim
	                    && (cnt_q <= len_t'(MAX_LEN - 2));
	assign overflow   = rx_valid && !is_delim && !store_one && !store_pair
	                    && ((state == DF_CONTENT) || (state == DF_CLOSE2));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= DF_HUNT;
			cnt_q    <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done  <= frame_end;
			rx_error <= overflow;
			if (store_one)
				cnt_q <= cnt_q + 6'd1;
			else if (store_pair)
				cnt_q <= cnt_q + 6'd2;
			else if (rx_valid && state == DF_OPEN2)
				cnt_q <= '0;

			if (rx_valid) begin
				case (state)
					DF_HUNT:
						if (is_delim)
							state <= DF_OPEN2;
					DF_OPEN2:
						state <= is_delim ? DF_CONTENT : DF_HUNT;
					DF_CONTENT:
						if (is_delim)
							state <= DF_CLOSE2;
						else if (overflow)
							state <= DF_HUNT;
					DF_CLOSE2:
						if (frame_end || overflow)
							state <= DF_HUNT;
						else
							state <= DF_CONTENT;
					default: state <= DF_HUNT;
				endcase
			end
		end
	end

	// payload buffer, cleared when a frame opens so unused bytes read zero
	always_ff @(posedge sys_clk) begin
		if (rx_valid && state == DF_OPEN2 && is_delim)
			data_q <= '0;
		if (store_one)
			data_q[8*cnt_q +: 8] <= rx_byte;
		if (store_pair) begin
			data_q[8*cnt_q +: 8]     <= DELIM;
			data_q[8*cnt_q + 8 +: 8] <= rx_byte;
		end
		if (frame_end)
			rx_msg <= '{data: data_q, length: cnt_q};
	end

	// delivered length never exceeds the buffer
	a_done_len: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> rx_msg.length <= len_t'(MAX_LEN)
	);

endmodule

`default_nettype wire

/* string_link/string_framer.sv */
//==========================================================================
// wraps a latched string as "&&payload&&" and feeds uart_tx byte by byte
// requests longer than MAX_LEN are clamped, tx_req while busy is dropped
// a zero length request sends "&&&&"
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module string_framer
	import uart_string_pkg::*;
(
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire str_msg_t tx_msg,
	input  wire           tx_req,
	output logic          tx_busy,
	output logic          tx_done,
	output byte_t         tx_byte,
	output logic          tx_start,
	input  wire           tx_byte_done
);

	framer_state_t state;
	string_t       data_q;
	len_t          len_q;
	len_t          byte_idx;
	logic          accept;

	// FINISH already counts as not busy
	assign tx_busy = (state != FR_IDLE) && (state != FR_FINISH);
	assign tx_done = (state == FR_FINISH);
	assign accept  = tx_req && !tx_busy;

	always_ff @(posedge sys_clk) begin
		if (accept)
			data_q <= tx_msg.data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= FR_IDLE;
			len_q    <= '0;
			byte_idx <= '0;
			tx_byte  <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (accept) begin
				len_q    <= (tx_msg.length > len_t'(MAX_LEN)) ? len_t'(MAX_LEN)
				                                               : tx_msg.length;
				byte_idx <= '0;
				tx_byte  <= DELIM;
				tx_start <= 1'b1;
				state    <= FR_OPEN1;
			end else if (state == FR_FINISH) begin
				state <= FR_IDLE;
			end else if (tx_byte_done) begin
				// each state names the byte now on the line
				case (state)
					FR_OPEN1: begin
						tx_byte  <= DELIM;
						tx_start <= 1'b1;
						state    <= FR_OPEN2;
					end
					FR_OPEN2, FR_PAYLOAD: begin
						tx_start <= 1'b1;
						if (byte_idx == len_q) begin
							tx_byte <= DELIM;
							state   <= FR_CLOSE1;
						end else begin
							tx_byte  <= data_q[8*byte_idx +: 8];
							byte_idx <= byte_idx + 6'd1;
							state    <= FR_PAYLOAD;
						end
					end
					FR_CLOSE1: begin
						tx_byte  <= DELIM;
						tx_start <= 1'b1;
						state    <= FR_CLOSE2;
					end
					FR_CLOSE2: state <= FR_FINISH;
					default:   state <= FR_IDLE;
				endcase
			end
		end
	end

	// clamp holds for the whole transfer, payload reads stay inside data_q
	a_len_clamped: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_busy |-> (len_q <= len_t'(MAX_LEN)) && (byte_idx <= len_q)
	);

endmodule

`default_nettype wire

/* uart_string_link.f */
common/uart_string_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
string_link/string_framer.sv
string_link/string_deframer.sv
hw/uart_string_link.sv
verification/tb_uart_string_link.sv

/* verification/tb_uart_string_link.sv */
//==========================================================================
// testbench for the uart string link, loopback and bit-banged receive
// expected rx results come from a reference deframer over the sent bytes
// bit-banged bytes use one stop bit, the DUT transmitter sends two
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_uart_string_link
	import uart_string_pkg::*;
();

	localparam int BIT_CYCLES        = int'(CLKS_PER_BIT);
	// worst case frame bytes of all six tests together
	localparam int TOTAL_FRAME_BYTES = 6 * (MAX_LEN + 4) + 36 + 4 + 13 + 46 + 13;
	localparam int CYCLE_LIMIT       = TOTAL_FRAME_BYTES * 11 * BIT_CYCLES + 100_000;
	localparam int FRAME_WAIT        = (MAX_LEN + 6) * 11 * BIT_CYCLES;

	logic     sys_clk;
	logic     sys_rst_n;
	str_msg_t tx_msg;
	logic     tx_req;
	logic     tx_busy;
	logic     tx_done;
	str_msg_t rx_msg;
	logic     rx_busy;
	logic     rx_done;
	logic     rx_error;
	logic     uart_rx_port;
	logic     uart_tx_port;
	logic     use_loop;
	logic     bang_line;

	int              errors;
	int              rx_evt_cnt;
	int              tx_done_cnt;
	int              cycle_cnt;
	string           cur_test;
	str_msg_t        exp_msg_q[$];
	bit              exp_err_q[$];
	byte_t           stream_q[$];
	deframer_state_t ref_state;
	int              ref_len;
	string_t         ref_data;
	bit              chk_err;
	str_msg_t        chk_msg;
	str_msg_t        msg;
	bit              rx_busy_seen;

	uart_string_link uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	// receive line from the transmitter or from the bit-banging task
	assign uart_rx_port = use_loop ? uart_tx_port : bang_line;

	initial sys_clk = 1'b0;
	always #10 sys_clk = ~sys_clk;

	task automatic check_value(input string name, input logic [261:0] expected,
	                           input logic [261:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic void push_result(input bit overflow);
		str_msg_t m;
		m.data   = ref_data;
		m.length = len_t'(ref_len);
		exp_msg_q.push_back(m);
		exp_err_q.push_back(overflow);
		ref_state = DF_HUNT;
	endfunction

	// state carries over between calls, like the line itself
	function automatic void ref_deframe(input byte_t bytes[$]);
		foreach (bytes[i]) begin
			case (ref_state)
				DF_HUNT:
					if (bytes[i] == DELIM)
						ref_state = DF_OPEN2;
				DF_OPEN2: begin
					ref_state = (bytes[i] == DELIM) ? DF_CONTENT : DF_HUNT;
					ref_len   = 0;
					ref_data  = '0;
				end
				DF_CONTENT:
					if (bytes[i] == DELIM) begin
						ref_state = DF_CLOSE2;
					end else if (ref_len < MAX_LEN) begin
						ref_data[8*ref_len +: 8] = bytes[i];
						ref_len++;
					end else begin
						push_result(1'b1);
					end
				DF_CLOSE2:
					if (bytes[i] == DELIM) begin
						push_result(1'b0);
					end else if (ref_len + 2 <= MAX_LEN) begin
						// a lone "&" belongs to the payload
						ref_data[8*ref_len +: 8]     = DELIM;
						ref_data[8*ref_len + 8 +: 8] = bytes[i];
						ref_len   += 2;
						ref_state = DF_CONTENT;
					end else begin
						push_result(1'b1);
					end
				default: ref_state = DF_HUNT;
			endcase
		end
	endfunction

	function automatic byte_t random_plain_byte();
		byte_t b;
		b = byte_t'($urandom);
		if (b == DELIM)
			b = b + 8'd1;
		return b;
	endfunction

	function automatic str_msg_t random_msg(input int len);
		str_msg_t m;
		m = '0;
		for (int i = 0; i < len && i < MAX_LEN; i++)
			m.data[8*i +: 8] = random_plain_byte();
		m.length = len_t'(len);
		return m;
	endfunction

	// bytes the framer should put on the line, length clamped to MAX_LEN
	function automatic void frame_of(input str_msg_t m);
		int n;
		n = (int'(m.length) > MAX_LEN) ? MAX_LEN : int'(m.length);
		stream_q = {DELIM, DELIM};
		for (int i = 0; i < n; i++)
			stream_q.push_back(m.data[8*i +: 8]);
		stream_q.push_back(DELIM);
		stream_q.push_back(DELIM);
	endfunction

	function automatic void add_text(input string s);
		for (int i = 0; i < s.len(); i++)
			stream_q.push_back(byte_t'(s[i]));
	endfunction

	task automatic drive_bit(input logic v);
		bang_line = v;
		repeat (BIT_CYCLES) @(negedge sys_clk);
	endtask

	// 8N1, lsb first
	task automatic send_bytes();
		foreach (stream_q[i]) begin
			drive_bit(1'b0);
			for (int b = 0; b < 8; b++)
				drive_bit(stream_q[i][b]);
			drive_bit(1'b1);
		end
	endtask

	// optional second tx_req in the middle of the transfer
	task automatic send_request(input str_msg_t m, input bit extra_req);
		int k;
		@(negedge sys_clk);
		tx_msg = m;
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		k = 0;
		while (!tx_done && k < FRAME_WAIT) begin
			check_value({cur_test, " tx_busy"}, 1, tx_busy);
			if (extra_req && k == 100) begin
				tx_msg = random_msg(5);
				tx_req = 1'b1;
			end else begin
				tx_req = 1'b0;
			end
			@(negedge sys_clk);
			k++;
		end
		tx_req = 1'b0;
		if (!tx_done) begin
			errors++;
			$display("test %s: tx_done never arrived after tx_req", cur_test);
		end
		check_value({cur_test, " tx_busy at tx_done"}, 0, tx_busy);
	endtask

	task automatic wait_expected();
		int k;
		k = 0;
		while (exp_err_q.size() != 0 && k < FRAME_WAIT) begin
			@(negedge sys_clk);
			k++;
		end
		if (exp_err_q.size() != 0) begin
			errors++;
			$display("test %s: %0d expected frame(s) gave no rx_done or rx_error",
			         cur_test, exp_err_q.size());
			exp_err_q.delete();
			exp_msg_q.delete();
		end
	endtask

	task automatic run_loopback(input string name, input str_msg_t m, input bit extra_req);
		int base_tx;
		int base_rx;
		cur_test = name;
		use_loop = 1'b1;
		base_tx  = tx_done_cnt;
		base_rx  = rx_evt_cnt;
		frame_of(m);
		ref_deframe(stream_q);
		send_request(m, extra_req);
		wait_expected();
		repeat (2 * BIT_CYCLES) @(negedge sys_clk);
		check_value({name, " tx_done count"}, base_tx + 1, tx_done_cnt);
		check_value({name, " rx frame count"}, base_rx + 1, rx_evt_cnt);
		check_value({name, " tx_busy after frame"}, 0, tx_busy);
		check_value({name, " rx_busy after frame"}, 0, rx_busy);
	endtask

	task automatic run_banged(input string name);
		cur_test = name;
		use_loop = 1'b0;
		ref_deframe(stream_q);
		send_bytes();
		wait_expected();
		repeat (2 * BIT_CYCLES) @(negedge sys_clk);
		check_value({name, " rx_busy after frame"}, 0, rx_busy);
	endtask

	// compare each rx_done or rx_error with the next expected entry
	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done)
			tx_done_cnt++;
		if (sys_rst_n && rx_busy)
			rx_busy_seen = 1'b1;
		if (sys_rst_n && (rx_done || rx_error)) begin
			rx_evt_cnt++;
			check_value({cur_test, " rx_busy during frame"}, 1, rx_busy_seen);
			rx_busy_seen = 1'b0;
			if (exp_err_q.size() == 0) begin
				errors++;
				$display("test %s: rx_done or rx_error arrived with no frame expected",
				         cur_test);
			end else begin
				chk_err = exp_err_q.pop_front();
				chk_msg = exp_msg_q.pop_front();
				check_value({cur_test, " rx_error"}, chk_err, rx_error);
				check_value({cur_test, " rx_done"}, !chk_err, rx_done);
				if (!chk_err) begin
					check_value({cur_test, " length"}, chk_msg.length, rx_msg.length);
					check_value({cur_test, " data"}, chk_msg.data, rx_msg.data);
				end
			end
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run exceeded %0d cycles in test %s", CYCLE_LIMIT, cur_test);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h3884_ea93));
		sys_rst_n    = 1'b0;
		tx_msg       = '0;
		tx_req       = 1'b0;
		use_loop     = 1'b1;
		bang_line    = 1'b1;
		errors       = 0;
		rx_evt_cnt   = 0;
		tx_done_cnt  = 0;
		cycle_cnt    = 0;
		cur_test     = "reset";
		ref_state    = DF_HUNT;
		ref_len      = 0;
		ref_data     = '0;
		rx_busy_seen = 1'b0;
		repeat (10) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (5) @(negedge sys_clk);

		for (int t = 0; t < 6; t++) begin
			msg = random_msg(1 + int'($urandom_range(31, 0)));
			run_loopback($sformatf("loopback_%0d", t), msg, 1'b0);
		end
		run_loopback("clamp_40", random_msg(40), 1'b0);
		run_loopback("empty", random_msg(0), 1'b0);

		// noise, a false opening, then "a&b"
		stream_q.delete();
		for (int i = 0; i < 4; i++)
			stream_q.push_back(random_plain_byte());
		add_text("&x");
		add_text("&&a&b&&");
		run_banged("noise_resync");

		// 33 payload bytes, then a good frame
		stream_q = {DELIM, DELIM};
		for (int i = 0; i < MAX_LEN + 1; i++)
			stream_q.push_back(random_plain_byte());
		add_text("&&ok&&");
		run_banged("overflow");

		run_loopback("busy_ignore", random_msg(8), 1'b1);

		$display("errors: %0d, rx frames: %0d, tx_done pulses: %0d",
		         errors, rx_evt_cnt, tx_done_cnt);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
